/* build.f */
+incdir+testbench
verilog/fxp_pkg.sv
verilog/stream_pkg.sv
verilog/fxp_complex_mult.sv
verilog/fxp_butterfly.sv
verilog/fxp_multi_butterfly.sv
verilog/stream_deserializer.sv
verilog/stream_serializer.sv
verilog/fxp_butterfly_harness.sv
testbench/tb_fxp_butterfly_harness.sv

/* testbench/tb_fxp_model.svh */
`ifndef TB_FXP_MODEL_SVH
`define TB_FXP_MODEL_SVH

// Product of two Q16.16 values divided by 2^FRAC. The quotient is rounded toward
// minus infinity, and only the low WIDTH bits survive.
function automatic fxp_pkg::fxp_t scaled_product(input fxp_pkg::fxp_t x,
                                                 input fxp_pkg::fxp_t y);
  longint prod;
  longint scale;
  longint quot;
  prod  = longint'(x) * longint'(y);
  scale = longint'(1) << fxp_pkg::FRAC;
  quot  = prod / scale;
  // Integer division truncates toward zero, so negative inexact results move down by one.
  if (prod < 0 && quot * scale != prod) begin
    quot = quot - 1;
  end
  return fxp_pkg::fxp_t'(quot);
endfunction

// Reference butterfly: t = w*b, c = a + t, d = a - t, all wrapping at WIDTH bits.
function automatic fxp_pkg::bfly_out_t model_butterfly(input fxp_pkg::bfly_in_t op);
  fxp_pkg::cplx_t     t;
  fxp_pkg::bfly_out_t r;
  t.re   = scaled_product(op.w.re, op.b.re) - scaled_product(op.w.im, op.b.im);
  t.im   = scaled_product(op.w.re, op.b.im) + scaled_product(op.w.im, op.b.re);
  r.c.re = op.a.re + t.re;
  r.c.im = op.a.im + t.im;
  r.d.re = op.a.re - t.re;
  r.d.im = op.a.im - t.im;
  return r;
endfunction

task automatic check_out(input string name, input fxp_pkg::bfly_out_t expected,
                         input fxp_pkg::bfly_out_t actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("MISMATCH %s: expected %h actual %h", name, expected, actual);
  end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("MISMATCH %s: expected %b actual %b", name, expected, actual);
  end
endtask

`endif

/* testbench/tb_fxp_butterfly_harness.sv */
`timescale 1ns/1ps

module tb_fxp_butterfly_harness;

  logic               clk;
  logic               rst_n;
  logic               recv_val;
  logic               recv_rdy;
  fxp_pkg::bfly_in_t  recv_msg;
  logic               send_val;
  logic               send_rdy;
  fxp_pkg::bfly_out_t send_msg;

  integer             seed;
  int                 errors;
  int                 checks;
  string              cur_test;
  logic               stall_seen;
  logic               stream_done;
  fxp_pkg::bfly_out_t exp_q[$];
  fxp_pkg::bfly_out_t next_exp;

  `include "tb_fxp_model.svh"

  fxp_butterfly_harness dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .recv_val(recv_val),
    .recv_rdy(recv_rdy),
    .recv_msg(recv_msg),
    .send_val(send_val),
    .send_rdy(send_rdy),
    .send_msg(send_msg)
  );

  always #20 clk = ~clk;

  // At the falling edge the output handshake already shows what the next rising
  // edge will transfer.
  always @(negedge clk) begin
    if (rst_n && send_val && send_rdy) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR %s: an output beat arrived when no result was expected", cur_test);
      end else begin
        next_exp = exp_q.pop_front();
        check_out(cur_test, next_exp, send_msg);
      end
    end
  end

  function automatic fxp_pkg::cplx_t make_cplx(input fxp_pkg::fxp_t re, input fxp_pkg::fxp_t im);
    fxp_pkg::cplx_t v;
    v.re = re;
    v.im = im;
    return v;
  endfunction

  // Operands with a negative b.re, so most products need floor rounding.
  task automatic random_operand(output fxp_pkg::bfly_in_t op);
    op.a.re = $random(seed) >>> 4;
    op.a.im = $random(seed) >>> 4;
    op.b.re = $random(seed) & 32'h00ff_ffff;
    op.b.re = -op.b.re - 1;
    op.b.im = $random(seed) >>> 8;
    op.w.re = $random(seed) % 32'sh0001_0000;
    op.w.im = $random(seed) % 32'sh0001_0000;
  endtask

  // Offers one beat and returns 1 ns after the edge that took it.
  task automatic send_beat(input fxp_pkg::bfly_in_t msg, input fxp_pkg::bfly_out_t expected);
    int cycles;
    cycles   = 0;
    recv_msg = msg;
    recv_val = 1'b1;
    @(negedge clk);
    while (!recv_rdy && cycles < 200) begin
      stall_seen = 1'b1;
      cycles++;
      @(negedge clk);
    end
    if (!recv_rdy) begin
      errors++;
      $display("ERROR %s: input beat was not accepted within 200 cycles", cur_test);
    end
    @(posedge clk);
    #1;
    recv_val = 1'b0;
    if (cycles < 200) begin
      exp_q.push_back(expected);
    end
  endtask

  task automatic send_modeled(input fxp_pkg::bfly_in_t msg);
    send_beat(msg, model_butterfly(msg));
  endtask

  task automatic wait_drain;
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (exp_q.size() != 0 && cycles < 200);
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR %s: %0d results did not arrive within 200 cycles", cur_test, exp_q.size());
      exp_q.delete();
    end
    #1;
  endtask

  task automatic test_reset;
    cur_test = "test_reset";
    @(negedge clk);
    check_bit(cur_test, 1'b0, send_val);
    check_bit(cur_test, 1'b1, recv_rdy);
    @(posedge clk);
    #1;
  endtask

  // With w = 1.0 the product is b exactly, so c and d are plain wrapping sums.
  task automatic test_unit_twiddle;
    fxp_pkg::bfly_in_t  op;
    fxp_pkg::bfly_out_t expected;
    int                 i;
    cur_test = "test_unit_twiddle";
    for (i = 0; i < 8; i++) begin
      random_operand(op);
      op.w = make_cplx(32'sh0001_0000, '0);
      case (i)
        0: begin
          op.a = make_cplx(32'sh7fff_ffff, 32'sh8000_0000);
          op.b = make_cplx(1, 1);
        end
        1: begin
          op.a = make_cplx(32'sh8000_0000, 32'sh7fff_ffff);
          op.b = make_cplx(32'sh8000_0000, 32'sh8000_0000);
        end
        2: begin
          op.a = make_cplx(32'sh0001_8000, -32'sh0002_4000);
          op.b = make_cplx(32'sh0000_8000, 32'sh0000_c000);
        end
        default: begin
        end
      endcase
      expected.c.re = op.a.re + op.b.re;
      expected.c.im = op.a.im + op.b.im;
      expected.d.re = op.a.re - op.b.re;
      expected.d.im = op.a.im - op.b.im;
      send_beat(op, expected);
    end
    wait_drain();
  endtask

  task automatic test_random_groups;
    fxp_pkg::bfly_in_t op;
    int                i;
    cur_test = "test_random_groups";
    for (i = 0; i < 8 * stream_pkg::N_LANES; i++) begin
      random_operand(op);
      send_modeled(op);
    end
    wait_drain();
  endtask

  // A zero twiddle returns a on both outputs, which tags each beat with its position.
  task automatic test_lane_order;
    fxp_pkg::bfly_in_t  op;
    fxp_pkg::bfly_out_t expected;
    int                 i;
    cur_test = "test_lane_order";
    for (i = 0; i < 3 * stream_pkg::N_LANES; i++) begin
      op.a = make_cplx(i * 65536, -i * 65536 - 7);
      op.b = make_cplx(i, -i);
      op.w = '0;
      expected.c = op.a;
      expected.d = op.a;
      send_beat(op, expected);
    end
    wait_drain();
  endtask

  task automatic test_backpressure;
    fxp_pkg::bfly_in_t op;
    int                i;
    cur_test   = "test_backpressure";
    send_rdy   = 1'b0;
    stall_seen = 1'b0;
    for (i = 0; i < 12; i++) begin
      random_operand(op);
      send_modeled(op);
    end
    check_bit(cur_test, 1'b1, stall_seen);
    // Serializer, array register and deserializer all hold a group now, so the
    // input stays blocked for as long as send_rdy is low.
    for (i = 0; i < 4; i++) begin
      @(negedge clk);
      check_bit(cur_test, 1'b0, recv_rdy);
      check_bit(cur_test, 1'b1, send_val);
      @(posedge clk);
      #1;
    end
    send_rdy = 1'b1;
    wait_drain();
  endtask

  task automatic test_streaming;
    fxp_pkg::bfly_in_t ops[64];
    int                i;
    int                cycles;
    cur_test    = "test_streaming";
    stream_done = 1'b0;
    for (i = 0; i < 64; i++) begin
      random_operand(ops[i]);
    end
    fork
      begin
        for (int k = 0; k < 64; k++) begin
          send_modeled(ops[k]);
        end
        stream_done = 1'b1;
      end
      begin
        cycles = 0;
        while (cycles < 64 * 200) begin
          send_rdy = ($random(seed) & 1) != 0;
          @(negedge clk);
          if (stream_done) begin
            break;
          end
          @(posedge clk);
          #1;
          cycles++;
        end
        @(posedge clk);
        #1;
        send_rdy = 1'b1;
      end
    join
    wait_drain();
    @(negedge clk);
    check_bit(cur_test, 1'b0, send_val);
    @(posedge clk);
    #1;
  endtask

  initial begin
    seed        = 32'h69ab_d95f;
    errors      = 0;
    checks      = 0;
    cur_test    = "reset";
    clk         = 1'b0;
    rst_n       = 1'b0;
    recv_val    = 1'b0;
    recv_msg    = '0;
    send_rdy    = 1'b1;
    stall_seen  = 1'b0;
    stream_done = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_unit_twiddle();
    test_random_groups();
    test_lane_order();
    test_backpressure();
    test_streaming();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* verilog/fxp_butterfly.sv */
`timescale 1ns/1ps

module fxp_butterfly (
  input  fxp_pkg::bfly_in_t  operand,
  output fxp_pkg::bfly_out_t result
);

  fxp_pkg::cplx_t t;

  // Twiddle-weighted second operand.
  fxp_complex_mult mult0 (
    .w(operand.w),
    .b(operand.b),
    .p(t)
  );

  // The sum and difference wrap at WIDTH bits.
  always_comb begin
    result.c.re = operand.a.re + t.re;
    result.c.im = operand.a.im + t.im;
    result.d.re = operand.a.re - t.re;
    result.d.im = operand.a.im - t.im;
  end

endmodule

/* verilog/fxp_butterfly_harness.sv */
`timescale 1ns/1ps

module fxp_butterfly_harness (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                recv_val,
  output logic                recv_rdy,
  input  fxp_pkg::bfly_in_t   recv_msg,

  output logic                send_val,
  input  logic                send_rdy,
  output fxp_pkg::bfly_out_t  send_msg
);

  logic                 vec_in_val;
  logic                 vec_in_rdy;
  stream_pkg::in_vec_t  vec_in;

  logic                 vec_out_val;
  logic                 vec_out_rdy;
  stream_pkg::out_vec_t vec_out;

  stream_deserializer #(
    .payload_t(fxp_pkg::bfly_in_t)
  ) deser0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .recv_val(recv_val),
    .recv_rdy(recv_rdy),
    .recv_msg(recv_msg),
    .send_val(vec_in_val),
    .send_rdy(vec_in_rdy),
    .send_msg(vec_in)
  );

  fxp_multi_butterfly bfly_array0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .vec_in_val (vec_in_val),
    .vec_in_rdy (vec_in_rdy),
    .vec_in     (vec_in),
    .vec_out_val(vec_out_val),
    .vec_out_rdy(vec_out_rdy),
    .vec_out    (vec_out)
  );

  stream_serializer #(
    .payload_t(fxp_pkg::bfly_out_t)
  ) ser0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .recv_val(vec_out_val),
    .recv_rdy(vec_out_rdy),
    .recv_msg(vec_out),
    .send_val(send_val),
    .send_rdy(send_rdy),
    .send_msg(send_msg)
  );

endmodule

/* verilog/fxp_complex_mult.sv */
`timescale 1ns/1ps

module fxp_complex_mult (
  input  fxp_pkg::cplx_t w,
  input  fxp_pkg::cplx_t b,
  output fxp_pkg::cplx_t p
);

  fxp_pkg::fxp_t rr;
  fxp_pkg::fxp_t cc;
  fxp_pkg::fxp_t rc;
  fxp_pkg::fxp_t cr;

  // Full-width signed product. The arithmetic shift floors toward minus infinity,
  // and the cast then keeps the low WIDTH bits.
  function automatic fxp_pkg::fxp_t fxp_mul(input fxp_pkg::fxp_t x, input fxp_pkg::fxp_t y);
    fxp_pkg::fxp_wide_t prod;
    prod = x * y;
    return fxp_pkg::fxp_t'(prod >>> fxp_pkg::FRAC);
  endfunction

  assign rr = fxp_mul(w.re, b.re);
  assign cc = fxp_mul(w.im, b.im);
  assign rc = fxp_mul(w.re, b.im);
  assign cr = fxp_mul(w.im, b.re);

  // Each partial product is scaled before the sum. The sums wrap on overflow.
  assign p.re = rr - cc;
  assign p.im = rc + cr;

endmodule

/* verilog/fxp_multi_butterfly.sv */
`timescale 1ns/1ps

module fxp_multi_butterfly (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  vec_in_val,
  output logic                  vec_in_rdy,
  input  stream_pkg::in_vec_t   vec_in,

  output logic                  vec_out_val,
  input  logic                  vec_out_rdy,
  output stream_pkg::out_vec_t  vec_out
);

  stream_pkg::out_vec_t result;
  stream_pkg::out_vec_t out_q;
  logic                 out_val_q;

  // One butterfly per lane. All lanes work on the same group at once.
  for (genvar i = 0; i < stream_pkg::N_LANES; i++) begin : g_lane
    fxp_butterfly bfly0 (
      .operand(vec_in[i]),
      .result (result[i])
    );
  end

  // The stage accepts a new group when it is empty, or when its current group
  // leaves on this same edge. This sustains one group per cycle.
  assign vec_in_rdy = !out_val_q || vec_out_rdy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_val_q <= 1'b0;
    end else if (vec_in_rdy) begin
      out_val_q <= vec_in_val;
    end
  end

  always_ff @(posedge clk) begin
    if (vec_in_val && vec_in_rdy) begin
      out_q <= result;
    end
  end

  assign vec_out_val = out_val_q;
  assign vec_out     = out_q;

endmodule

/* verilog/fxp_pkg.sv */
package fxp_pkg;

  // Signed fixed point in Q16.16. The binary point sits FRAC bits up from the LSB.
  localparam int WIDTH = 32;
  localparam int FRAC = 16;

  typedef logic signed [WIDTH-1:0] fxp_t;

  // A full-precision product of two fxp_t values, before it is scaled back down.
  typedef logic signed [2*WIDTH-1:0] fxp_wide_t;

  // Complex value. The real part occupies the upper half of the word.
  typedef struct packed {
    fxp_t re;
    fxp_t im;
  } cplx_t;

  // One butterfly operand set, 192 bits.
  // From MSB to LSB the fields are ar, ac, br, bc, wr, wc, the same as the raw stream beat.
  typedef struct packed {
    cplx_t a;
    cplx_t b;
    cplx_t w;
  } bfly_in_t;

  // Butterfly outputs, with c = a + w*b and d = a - w*b.
  // The field order cr, cc, dr, dc matches the 128-bit output beat.
  typedef struct packed {
    cplx_t c;
    cplx_t d;
  } bfly_out_t;

endpackage

/* verilog/stream_deserializer.sv */
`timescale 1ns/1ps

module stream_deserializer #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                                clk,
  input  logic                                rst_n,

  input  logic                                recv_val,
  output logic                                recv_rdy,
  input  payload_t                            recv_msg,

  output logic                                send_val,
  input  logic                                send_rdy,
  output payload_t [stream_pkg::N_LANES-1:0]  send_msg
);

  payload_t [stream_pkg::N_LANES-1:0] buf_q;
  logic [stream_pkg::LANE_W-1:0]      lane;
  logic                               full;

  // Input is refused while a complete group waits to be taken.
  assign recv_rdy = !full;
  assign send_val = full;
  assign send_msg = buf_q;

  // The lane counter wraps back to 0 on the last beat, so a new group starts
  // at lane 0 as soon as the full group is taken.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane <= '0;
      full <= 1'b0;
    end else begin
      if (recv_val && recv_rdy) begin
        if (lane == stream_pkg::LAST_LANE) begin
          lane <= '0;
          full <= 1'b1;
        end else begin
          lane <= lane + 1'b1;
        end
      end
      if (send_val && send_rdy) begin
        full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      buf_q[lane] <= recv_msg;
    end
  end

endmodule

/* verilog/stream_pkg.sv */
package stream_pkg;

  // Beats per group. There is one butterfly lane per beat.
  localparam int N_LANES = 4;

  // Width of a lane index, and the index of the final beat in a group.
  localparam int LANE_W = $clog2(N_LANES);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(N_LANES - 1);

  // Index 0 holds the first beat of a group on both sides of the array.
  typedef fxp_pkg::bfly_in_t [N_LANES-1:0] in_vec_t;
  typedef fxp_pkg::bfly_out_t [N_LANES-1:0] out_vec_t;

endpackage

/* verilog/stream_serializer.sv */
`timescale 1ns/1ps

module stream_serializer #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                                clk,
  input  logic                                rst_n,

  input  logic                                recv_val,
  output logic                                recv_rdy,
  input  payload_t [stream_pkg::N_LANES-1:0]  recv_msg,

  output logic                                send_val,
  input  logic                                send_rdy,
  output payload_t                            send_msg
);

  payload_t [stream_pkg::N_LANES-1:0] buf_q;
  logic [stream_pkg::LANE_W-1:0]      lane;
  logic                               busy;

  // A new group is loaded only once the previous one has been fully sent.
  assign recv_rdy = !busy;
  assign send_val = busy;
  assign send_msg = buf_q[lane];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      lane <= '0;
    end else if (recv_val && recv_rdy) begin
      busy <= 1'b1;
      lane <= '0;
    end else if (send_val && send_rdy) begin
      // Go idle after the last beat goes out.
      if (lane == stream_pkg::LAST_LANE) begin
        busy <= 1'b0;
        lane <= '0;
      end else begin
        lane <= lane + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      buf_q <= recv_msg;
    end
  end

endmodule
